//--- ntm_settings.svh
////////////////////////////////////////
// Q1.15 unsigned words, 1.0 is 0x8000
// Index widths must cover R_MAX and N_MAX
////////////////////////////////////////

`ifndef NTM_SETTINGS_SVH
`define NTM_SETTINGS_SVH

// Fixed-point word
`define NTM_DATA_W 16
`define NTM_FRAC_W 15

// Array limits
`define NTM_R_MAX 8
`define NTM_N_MAX 16

// Index and size widths
`define NTM_HEAD_W 3
`define NTM_LOC_W 4
`define NTM_SIZE_W 5

`endif

//--- ntm_types_pkg.sv
////////////////////////////////////////
// Scalar types and controller states
////////////////////////////////////////

`include "ntm_settings.svh"

package ntm_types_pkg;

  // Unsigned Q1.15 word
  typedef logic [`NTM_DATA_W-1:0] fix_t;

  // Head index, 0 to R_MAX-1
  typedef logic [`NTM_HEAD_W-1:0] head_idx_t;

  // Memory location index, 0 to N_MAX-1
  typedef logic [`NTM_LOC_W-1:0] loc_idx_t;

  // Count of heads or locations, up to the max itself
  typedef logic [`NTM_SIZE_W-1:0] size_t;

  // Fixed-point 1.0
  localparam fix_t fix_one = fix_t'(1 << `NTM_FRAC_W);

  // Retention controller phases
  typedef enum logic [1:0] {IDLE, LOAD, UPDATE, DRAIN} ctrl_state_t;

endpackage

//--- ntm_bus_pkg.sv
////////////////////////////////////////
// Element buses between the blocks
////////////////////////////////////////

package ntm_bus_pkg;

  // One tagged weight w(i,j)
  typedef struct packed {
    // Element present this cycle
    logic                    valid;
    // Head i and location j
    ntm_types_pkg::head_idx_t head;
    ntm_types_pkg::loc_idx_t  loc;
    // Final weight of the run
    logic                    last;
    // Previous read weighting
    ntm_types_pkg::fix_t      w;
  } weight_elem_t;

  // One retention result
  typedef struct packed {
    ntm_types_pkg::loc_idx_t loc;
    ntm_types_pkg::fix_t     psi;
  } psi_elem_t;

endpackage

//--- free_gate_store.sv
////////////////////////////////////////
// Gates land in arrival order, at most R_MAX per run
////////////////////////////////////////

`include "ntm_settings.svh"

module free_gate_store (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  logic                     F_IN_ENABLE,
  input  ntm_types_pkg::fix_t       F_IN,
  input  ntm_types_pkg::head_idx_t  rd_head,
  output ntm_types_pkg::fix_t       gate
);

  // Gate registers, one per head
  ntm_types_pkg::fix_t gate_mem [`NTM_R_MAX];

  // Next free slot, one bit wider to see overflow
  ntm_types_pkg::size_t wr_ptr;

  // Write pointer
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
    end else if (START) begin
      wr_ptr <= '0;
    end else if (F_IN_ENABLE) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Gate capture
  always_ff @(posedge CLK) begin
    if (F_IN_ENABLE && !START) begin
      gate_mem[ntm_types_pkg::head_idx_t'(wr_ptr)] <= F_IN;
    end
  end

  // Read for the element the sequencer holds
  assign gate = gate_mem[rd_head];

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // More gates than slots since START
  a_no_overflow : assert property (@(posedge CLK) disable iff (RST)
    F_IN_ENABLE && !START |-> wr_ptr < ntm_types_pkg::size_t'(`NTM_R_MAX));

  // Gate above 1.0
  a_gate_range : assert property (@(posedge CLK) disable iff (RST)
    F_IN_ENABLE |-> F_IN <= ntm_types_pkg::fix_one);

endmodule

//--- weight_sequencer.sv
////////////////////////////////////////
// Weights come i outer, j inner; R and N taken on START
////////////////////////////////////////

`include "ntm_settings.svh"

module weight_sequencer (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       START,
  input  ntm_types_pkg::size_t        SIZE_R_IN,
  input  ntm_types_pkg::size_t        SIZE_N_IN,
  input  logic                       W_IN_ENABLE,
  input  ntm_types_pkg::fix_t         W_IN,
  output ntm_bus_pkg::weight_elem_t   elem,
  output ntm_types_pkg::head_idx_t    cur_head
);

  // Latched run sizes
  ntm_types_pkg::size_t size_r_q;
  ntm_types_pkg::size_t size_n_q;

  // Position of the next incoming weight
  ntm_types_pkg::head_idx_t head_cnt;
  ntm_types_pkg::loc_idx_t  loc_cnt;

  // Final weight already seen
  logic done_q;

  // Registered element
  logic                     valid_q;
  ntm_types_pkg::head_idx_t head_q;
  ntm_types_pkg::loc_idx_t  loc_q;
  logic                     last_q;
  ntm_types_pkg::fix_t      w_q;

  // End of a row and end of the run
  logic row_end;
  logic run_end;

  assign row_end = ntm_types_pkg::size_t'(loc_cnt) == size_n_q - `NTM_SIZE_W'(1);
  assign run_end = row_end &&
                   (ntm_types_pkg::size_t'(head_cnt) == size_r_q - `NTM_SIZE_W'(1));

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_r_q <= '0;
      size_n_q <= '0;
      head_cnt <= '0;
      loc_cnt  <= '0;
      done_q   <= 1'b0;
      valid_q  <= 1'b0;
    end else if (START) begin
      size_r_q <= SIZE_R_IN;
      size_n_q <= SIZE_N_IN;
      head_cnt <= '0;
      loc_cnt  <= '0;
      done_q   <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= W_IN_ENABLE;
      if (W_IN_ENABLE) begin
        // j wraps at N, then i steps
        if (row_end) begin
          loc_cnt  <= '0;
          head_cnt <= head_cnt + 1'b1;
        end else begin
          loc_cnt <= loc_cnt + 1'b1;
        end
        done_q <= run_end;
      end
    end
  end

  // Payload and tags
  always_ff @(posedge CLK) begin
    if (W_IN_ENABLE) begin
      head_q <= head_cnt;
      loc_q  <= loc_cnt;
      last_q <= run_end;
      w_q    <= W_IN;
    end
  end

  assign elem = '{valid: valid_q, head: head_q, loc: loc_q, last: last_q, w: w_q};

  // Store read lines up with the registered element
  assign cur_head = head_q;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Weight past the end of the run
  a_no_extra_weight : assert property (@(posedge CLK) disable iff (RST)
    W_IN_ENABLE |-> !done_q);

  // Weight above 1.0
  a_weight_range : assert property (@(posedge CLK) disable iff (RST)
    W_IN_ENABLE |-> W_IN <= ntm_types_pkg::fix_one);

endmodule

//--- retention_accumulator.sv
////////////////////////////////////////
// psi(j) *= 1 - f(i)*w(i,j), truncated Q1.15
// N taken on START, N must be at least 1
////////////////////////////////////////

`include "ntm_settings.svh"

module retention_accumulator (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  ntm_types_pkg::size_t       SIZE_N_IN,
  input  ntm_bus_pkg::weight_elem_t  elem,
  input  ntm_types_pkg::fix_t        gate,
  output logic                      PSI_OUT_ENABLE,
  output ntm_bus_pkg::psi_elem_t     PSI_OUT,
  output logic                      READY
);

  // Controller
  ntm_types_pkg::ctrl_state_t state;
  ntm_types_pkg::size_t       size_n_q;
  ntm_types_pkg::loc_idx_t    drain_cnt;
  logic                      drain_end;

  // Retention per location
  ntm_types_pkg::fix_t psi_mem [`NTM_N_MAX];

  // Datapath
  ntm_types_pkg::fix_t erase;
  ntm_types_pkg::fix_t keep;
  ntm_types_pkg::fix_t psi_new;

  // Q1.15 product, low fraction bits dropped
  function automatic ntm_types_pkg::fix_t fix_mul(input ntm_types_pkg::fix_t a,
                                                  input ntm_types_pkg::fix_t b);
    logic [2*`NTM_DATA_W-1:0] prod;
    prod = a * b;
    return prod[`NTM_FRAC_W +: `NTM_DATA_W];
  endfunction

  ////////////////////////////////////////
  // Update path
  ////////////////////////////////////////

  // g = f*w, r = 1 - g, psi*r
  assign erase   = fix_mul(gate, elem.w);
  assign keep    = ntm_types_pkg::fix_one - erase;
  assign psi_new = fix_mul(psi_mem[elem.loc], keep);

  assign drain_end = ntm_types_pkg::size_t'(drain_cnt) == size_n_q - `NTM_SIZE_W'(1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_types_pkg::IDLE;
      size_n_q  <= '0;
      drain_cnt <= '0;
      READY     <= 1'b0;
      for (int k = 0; k < `NTM_N_MAX; k++) psi_mem[k] <= '0;
    end else begin
      READY <= 1'b0;
      if (START) begin
        // New run, restart from full retention
        state     <= ntm_types_pkg::LOAD;
        size_n_q  <= SIZE_N_IN;
        drain_cnt <= '0;
        for (int k = 0; k < `NTM_N_MAX; k++) psi_mem[k] <= ntm_types_pkg::fix_one;
      end else begin
        case (state)
          ntm_types_pkg::LOAD, ntm_types_pkg::UPDATE: begin
            if (elem.valid) begin
              psi_mem[elem.loc] <= psi_new;
              state <= elem.last ? ntm_types_pkg::DRAIN : ntm_types_pkg::UPDATE;
            end
          end
          ntm_types_pkg::DRAIN: begin
            // One location per cycle, READY after the last
            if (drain_end) begin
              state     <= ntm_types_pkg::IDLE;
              drain_cnt <= '0;
              READY     <= 1'b1;
            end else begin
              drain_cnt <= drain_cnt + 1'b1;
            end
          end
          default: state <= ntm_types_pkg::IDLE;
        endcase
      end
    end
  end

  // Output stream straight from the array
  assign PSI_OUT_ENABLE = state == ntm_types_pkg::DRAIN;
  assign PSI_OUT        = '{loc: drain_cnt, psi: psi_mem[drain_cnt]};

  // READY only right after the last psi word
  a_ready_after_drain : assert property (@(posedge CLK) disable iff (RST)
    READY |-> !PSI_OUT_ENABLE && $past(PSI_OUT_ENABLE));

endmodule

//--- memory_retention_vector.sv
////////////////////////////////////////
// No back-pressure, inputs must not exceed 1.0
////////////////////////////////////////

module memory_retention_vector (
  // Global
  input  logic                   CLK,
  input  logic                   RST,

  // Control
  input  logic                   START,
  output logic                   READY,

  // Sizes, sampled on START
  input  ntm_types_pkg::size_t    SIZE_R_IN,
  input  ntm_types_pkg::size_t    SIZE_N_IN,

  // Free gates then weights
  input  logic                   F_IN_ENABLE,
  input  ntm_types_pkg::fix_t     F_IN,
  input  logic                   W_IN_ENABLE,
  input  ntm_types_pkg::fix_t     W_IN,

  // Retention stream
  output logic                   PSI_OUT_ENABLE,
  output ntm_bus_pkg::psi_elem_t  PSI_OUT
);

  // Tagged weight and its gate
  ntm_bus_pkg::weight_elem_t elem;
  ntm_types_pkg::head_idx_t  cur_head;
  ntm_types_pkg::fix_t       gate;

  // Gates
  free_gate_store u_free_gate_store (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .F_IN_ENABLE(F_IN_ENABLE),
    .F_IN       (F_IN),
    .rd_head    (cur_head),
    .gate       (gate)
  );

  // Weight indexing
  weight_sequencer u_weight_sequencer (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .SIZE_R_IN  (SIZE_R_IN),
    .SIZE_N_IN  (SIZE_N_IN),
    .W_IN_ENABLE(W_IN_ENABLE),
    .W_IN       (W_IN),
    .elem       (elem),
    .cur_head   (cur_head)
  );

  // psi update and drain
  retention_accumulator u_retention_accumulator (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .SIZE_N_IN     (SIZE_N_IN),
    .elem          (elem),
    .gate          (gate),
    .PSI_OUT_ENABLE(PSI_OUT_ENABLE),
    .PSI_OUT       (PSI_OUT),
    .READY         (READY)
  );

endmodule

//--- tb_memory_retention_vector.sv
////////////////////////////////////////
// Fixed LFSR seed, one case table run in order
////////////////////////////////////////

`include "ntm_settings.svh"

module tb_memory_retention_vector;

  localparam int NUM_CASES = 8;
  localparam logic [31:0] LFSR_SEED = 32'h99c8;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  typedef enum int {MODE_RANDOM, MODE_ZERO, MODE_ERASE, MODE_B2B} run_mode_t;

  // Case table: name, R, N, mode
  string     case_name [NUM_CASES] = '{"zero_gates", "erase_row", "rand_1x1", "rand_8x16",
                                       "rand_4x7", "b2b_3x4", "b2b_5x2", "rand_2x16"};
  int        case_r    [NUM_CASES] = '{3, 2, 1, 8, 4, 3, 5, 2};
  int        case_n    [NUM_CASES] = '{5, 6, 1, 16, 7, 4, 2, 16};
  run_mode_t case_mode [NUM_CASES] = '{MODE_ZERO, MODE_ERASE, MODE_RANDOM, MODE_RANDOM,
                                       MODE_RANDOM, MODE_B2B, MODE_B2B, MODE_RANDOM};

  // DUT ports
  logic CLK = 1'b0;
  logic RST;
  logic START;
  logic READY;
  ntm_types_pkg::size_t   SIZE_R_IN;
  ntm_types_pkg::size_t   SIZE_N_IN;
  logic                   F_IN_ENABLE;
  ntm_types_pkg::fix_t    F_IN;
  logic                   W_IN_ENABLE;
  ntm_types_pkg::fix_t    W_IN;
  logic                   PSI_OUT_ENABLE;
  ntm_bus_pkg::psi_elem_t PSI_OUT;

  // Stimulus and reference results
  ntm_types_pkg::fix_t gates   [`NTM_R_MAX];
  ntm_types_pkg::fix_t weights [`NTM_R_MAX][`NTM_N_MAX];
  ntm_types_pkg::fix_t exp_psi [`NTM_N_MAX];

  logic [31:0] lfsr_state;
  string       cur_name;
  int          psi_errors = 0;
  int          flag_errors = 0;
  int          stream_errors = 0;
  int          cycle_cnt = 0;
  int          limit_cycles = 0;

  // Controller state, only for messages
  ntm_types_pkg::ctrl_state_t acc_state;
  assign acc_state = u_memory_retention_vector.u_retention_accumulator.state;

  memory_retention_vector u_memory_retention_vector (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .READY         (READY),
    .SIZE_R_IN     (SIZE_R_IN),
    .SIZE_N_IN     (SIZE_N_IN),
    .F_IN_ENABLE   (F_IN_ENABLE),
    .F_IN          (F_IN),
    .W_IN_ENABLE   (W_IN_ENABLE),
    .W_IN          (W_IN),
    .PSI_OUT_ENABLE(PSI_OUT_ENABLE),
    .PSI_OUT       (PSI_OUT)
  );

  always #4 CLK = ~CLK;

  // Watchdog
  always @(posedge CLK) begin
    cycle_cnt++;
    if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
      $display("Timeout after %0d cycles in %s, accumulator in state %s",
               cycle_cnt, cur_name, acc_state.name());
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Random values
  ////////////////////////////////////////

  // Galois step, returns the bit shifted out
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ LFSR_TAPS;
    return out;
  endfunction

  // 15 bits, never above 1.0
  function automatic ntm_types_pkg::fix_t rand_fix();
    ntm_types_pkg::fix_t v;
    v = '0;
    for (int b = 0; b < 15; b++) v = {v[14:0], lfsr_bit()};
    if (v > ntm_types_pkg::fix_one) v = ntm_types_pkg::fix_one;
    return v;
  endfunction

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Inputs change 1 unit after the edge, outputs are settled there
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic check_psi(input ntm_bus_pkg::psi_elem_t exp, input ntm_bus_pkg::psi_elem_t act);
    if (act !== exp) begin
      psi_errors++;
      $display("error %s: expected loc %0d psi 0x%04h, actual loc %0d psi 0x%04h",
               cur_name, exp.loc, exp.psi, act.loc, act.psi);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errors++;
      $display("error %s %s: expected %0b, actual %0b", cur_name, what, exp, act);
    end
  endtask

  // Quiet cycles, no stream and no READY
  task automatic idle_cycles(input int n);
    repeat (n) begin
      next_cycle();
      check_flag("idle ready", 1'b0, READY);
      check_flag("idle psi enable", 1'b0, PSI_OUT_ENABLE);
    end
  endtask

  task automatic build_stimulus(input run_mode_t mode, input int r, input int n);
    for (int i = 0; i < `NTM_R_MAX; i++) begin
      gates[i] = '0;
      for (int j = 0; j < `NTM_N_MAX; j++) weights[i][j] = '0;
    end
    for (int i = 0; i < r; i++) begin
      gates[i] = (mode == MODE_ZERO) ? '0 : rand_fix();
      for (int j = 0; j < n; j++) weights[i][j] = rand_fix();
    end
    // Full erase of the middle location by head 0
    if (mode == MODE_ERASE) begin
      gates[0] = ntm_types_pkg::fix_one;
      weights[0][n / 2] = ntm_types_pkg::fix_one;
    end
  endtask

  // psi(j) = prod over i of (1 - f(i)w(i,j)), truncated after each product
  task automatic compute_model(input int r, input int n);
    logic [31:0] prod;
    logic [31:0] keep;
    for (int j = 0; j < n; j++) exp_psi[j] = ntm_types_pkg::fix_one;
    for (int i = 0; i < r; i++) begin
      for (int j = 0; j < n; j++) begin
        prod = 32'(gates[i]) * 32'(weights[i][j]);
        keep = 32'h8000 - (prod >> 15);
        prod = 32'(exp_psi[j]) * keep;
        exp_psi[j] = ntm_types_pkg::fix_t'(prod >> 15);
      end
    end
  endtask

  ////////////////////////////////////////
  // One run
  ////////////////////////////////////////

  task automatic run_case(input int idx);
    int r;
    int n;
    int got;
    int waited;
    ntm_bus_pkg::psi_elem_t exp_elem;
    r = case_r[idx];
    n = case_n[idx];
    cur_name = case_name[idx];
    build_stimulus(case_mode[idx], r, n);
    compute_model(r, n);
    // Back-to-back runs start in the READY cycle
    if (case_mode[idx] != MODE_B2B) idle_cycles(3);
    START = 1'b1;
    SIZE_R_IN = ntm_types_pkg::size_t'(r);
    SIZE_N_IN = ntm_types_pkg::size_t'(n);
    next_cycle();
    START = 1'b0;
    check_flag("ready after start", 1'b0, READY);
    check_flag("psi enable after start", 1'b0, PSI_OUT_ENABLE);
    for (int i = 0; i < r; i++) begin
      F_IN_ENABLE = 1'b1;
      F_IN = gates[i];
      next_cycle();
    end
    F_IN_ENABLE = 1'b0;
    // Row order, i outer
    for (int i = 0; i < r; i++) begin
      for (int j = 0; j < n; j++) begin
        W_IN_ENABLE = 1'b1;
        W_IN = weights[i][j];
        next_cycle();
      end
    end
    W_IN_ENABLE = 1'b0;
    got = 0;
    waited = 0;
    while (got < n && waited < n + 8) begin
      if (PSI_OUT_ENABLE) begin
        exp_elem.loc = ntm_types_pkg::loc_idx_t'(got);
        exp_elem.psi = exp_psi[got];
        check_psi(exp_elem, PSI_OUT);
        got++;
      end else if (got > 0) begin
        stream_errors++;
        $display("Gap in the psi stream of %s after %0d words", cur_name, got);
      end
      check_flag("ready during stream", 1'b0, READY);
      next_cycle();
      waited++;
    end
    if (got < n) begin
      stream_errors++;
      $display("Psi stream of %s ended short, %0d of %0d words", cur_name, got, n);
    end
    check_flag("ready after last psi", 1'b1, READY);
    check_flag("psi enable with ready", 1'b0, PSI_OUT_ENABLE);
  endtask

  initial begin
    RST = 1'b1;
    START = 1'b0;
    SIZE_R_IN = '0;
    SIZE_N_IN = '0;
    F_IN_ENABLE = 1'b0;
    F_IN = '0;
    W_IN_ENABLE = 1'b0;
    W_IN = '0;
    lfsr_state = LFSR_SEED;
    cur_name = "after_reset";
    // Budget: start-up plus every run with margin
    limit_cycles = 16;
    for (int k = 0; k < NUM_CASES; k++) begin
      limit_cycles += case_r[k] + case_r[k] * case_n[k] + case_n[k] + 20;
    end
    repeat (4) @(posedge CLK);
    #1 RST = 1'b0;
    idle_cycles(6);
    for (int k = 0; k < NUM_CASES; k++) run_case(k);
    idle_cycles(2);
    $display("Errors: psi %0d, flag %0d, stream %0d", psi_errors, flag_errors, stream_errors);
    if (psi_errors + flag_errors + stream_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
ntm_types_pkg.sv
ntm_bus_pkg.sv
free_gate_store.sv
weight_sequencer.sv
retention_accumulator.sv
memory_retention_vector.sv
tb_memory_retention_vector.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the retention vector testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_memory_retention_vector
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module "$TOP" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
